// ==== Makefile ====
# Verilator build and run for the system-instruction unit testbench

SIM = obj_dir/sys_unit_sim
LOG = sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module sys_unit_tb -f all.f \
		-Mdir obj_dir -o sys_unit_sim

run: compile
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== all.f ====
+incdir+include
hw/sys_pkg.sv
hw/sys_decode.sv
hw/csr_regfile.sv
hw/sys_writeback.sv
hw/sys_unit.sv
sim/sys_unit_sva.sv
sim/sys_unit_tb.sv

// ==== hw/csr_regfile.sv ====
`timescale 1ns/100ps
`include "sys_config.svh"

module csr_regfile import sys_pkg::*; (
	input logic clock,
	input logic reset,
	input logic issue,
	input sys_cmd_t cmd,
	input logic [`SYS_XLEN-1:0] pc,
	output logic [`SYS_XLEN-1:0] rd_old,
	output logic [`SYS_XLEN-1:0] mstatus,
	output logic [`SYS_XLEN-1:0] mtvec,
	output logic [`SYS_XLEN-1:0] mepc
);

	logic [`SYS_XLEN-1:0] mcause;

	logic is_ecall;
	logic is_mret;
	logic is_csr_op;
	logic sel_mstatus;
	logic sel_mtvec;
	logic sel_mepc;
	logic sel_mcause;
	logic [`SYS_XLEN-1:0] wdata;

	logic mstatus_we;
	logic mtvec_we;
	logic mepc_we;
	logic mcause_we;
	logic [`SYS_XLEN-1:0] mstatus_next;
	logic [`SYS_XLEN-1:0] mepc_next;
	logic [`SYS_XLEN-1:0] mcause_next;

	assign is_ecall = (cmd.op == SYS_ECALL);
	assign is_mret = (cmd.op == SYS_MRET);
	assign is_csr_op = (cmd.op == SYS_CSRRW) || (cmd.op == SYS_CSRRS) || (cmd.op == SYS_CSRRC);

	assign sel_mstatus = (cmd.csr == CSR_MSTATUS);
	assign sel_mtvec = (cmd.csr == CSR_MTVEC);
	assign sel_mepc = (cmd.csr == CSR_MEPC);
	assign sel_mcause = (cmd.csr == CSR_MCAUSE);

	always_comb begin
		case (cmd.csr)
			CSR_MSTATUS: rd_old = mstatus;
			CSR_MTVEC: rd_old = mtvec;
			CSR_MEPC: rd_old = mepc;
			CSR_MCAUSE: rd_old = mcause;
			CSR_MVENDORID: rd_old = `SYS_MVENDORID;
			CSR_MARCHID: rd_old = `SYS_MARCHID;
			default: rd_old = '0;
		endcase
	end

	// Read-modify-write result built from the value being returned to rd
	always_comb begin
		case (cmd.op)
			SYS_CSRRS: wdata = rd_old | cmd.operand;
			SYS_CSRRC: wdata = rd_old & ~cmd.operand;
			default: wdata = cmd.operand;
		endcase
	end

	// Read-only and unknown addresses have no select, so their writes fall away
	assign mstatus_we = issue && (is_ecall || is_mret || (is_csr_op && sel_mstatus));
	assign mtvec_we = issue && is_csr_op && sel_mtvec;
	assign mepc_we = issue && (is_ecall || (is_csr_op && sel_mepc));
	assign mcause_we = issue && (is_ecall || (is_csr_op && sel_mcause));

	always_comb begin
		if (is_ecall) begin
			mstatus_next = `SYS_MSTATUS_TRAP;
		end else if (is_mret) begin
			mstatus_next = '0; // Back to the state before trap entry
		end else begin
			mstatus_next = wdata;
		end
	end

	assign mepc_next = is_ecall ? pc : wdata;
	assign mcause_next = is_ecall ? `SYS_ECALL_CAUSE : wdata;

	always_ff @(posedge clock) begin
		if (reset) begin
			mstatus <= '0;
			mtvec <= '0;
			mepc <= '0;
			mcause <= '0;
		end else begin
			if (mstatus_we) begin
				mstatus <= mstatus_next;
			end
			if (mtvec_we) begin
				mtvec <= wdata;
			end
			if (mepc_we) begin
				mepc <= mepc_next;
			end
			if (mcause_we) begin
				mcause <= mcause_next;
			end
		end
	end

endmodule

// ==== hw/sys_decode.sv ====
`timescale 1ns/100ps
`include "sys_config.svh"

module sys_decode import sys_pkg::*; (
	input logic [31:0] instr,
	input logic [`SYS_XLEN-1:0] src1,
	output sys_cmd_t cmd
);

	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;
	localparam logic [11:0] IMM_ECALL = 12'h000;
	localparam logic [11:0] IMM_MRET = 12'h302;

	logic [6:0] opcode;
	logic [4:0] rd_field;
	logic [2:0] funct3;
	logic [4:0] rs1_field;
	logic [11:0] imm_field;
	logic [`SYS_XLEN-1:0] zimm;

	assign opcode = instr[6:0];
	assign rd_field = instr[11:7];
	assign funct3 = instr[14:12];
	assign rs1_field = instr[19:15];
	assign imm_field = instr[31:20];

	// The rs1 field doubles as a 5-bit unsigned immediate in the CSR*I forms
	assign zimm = {{(`SYS_XLEN-5){1'b0}}, rs1_field};

	always_comb begin
		cmd.op = SYS_NONE;
		cmd.csr = imm_field;
		cmd.rd = rd_field;
		cmd.operand = funct3[2] ? zimm : src1;

		if (opcode == OPC_SYSTEM) begin
			case (funct3)
				3'b000: begin
					if (imm_field == IMM_ECALL) begin
						cmd.op = SYS_ECALL;
					end else if (imm_field == IMM_MRET) begin
						cmd.op = SYS_MRET;
					end
				end
				3'b001, 3'b101: cmd.op = SYS_CSRRW;
				3'b010, 3'b110: cmd.op = SYS_CSRRS;
				3'b011, 3'b111: cmd.op = SYS_CSRRC;
				default: cmd.op = SYS_NONE; // 100 is reserved
			endcase
		end
	end

endmodule

// ==== hw/sys_pkg.sv ====
`include "sys_config.svh"

package sys_pkg;

	typedef enum logic [2:0] {
		SYS_NONE,
		SYS_ECALL,
		SYS_MRET,
		SYS_CSRRW,
		SYS_CSRRS,
		SYS_CSRRC
	} sys_op_e;

	// Machine CSRs this unit answers to
	typedef enum logic [11:0] {
		CSR_MSTATUS = 12'h300,
		CSR_MTVEC = 12'h305,
		CSR_MEPC = 12'h341,
		CSR_MCAUSE = 12'h342,
		CSR_MVENDORID = 12'hF11,
		CSR_MARCHID = 12'hF12
	} csr_addr_e;

	typedef struct packed {
		sys_op_e op;
		logic [11:0] csr;
		logic [4:0] rd;
		logic [`SYS_XLEN-1:0] operand; // Already selected between rs1 value and zimm
	} sys_cmd_t;

	typedef struct packed {
		logic valid;
		logic rd_we;
		logic [4:0] rd;
		logic [`SYS_XLEN-1:0] rd_data;
		logic redirect;
		logic [`SYS_XLEN-1:0] target;
	} sys_wb_t;

endpackage

// ==== hw/sys_unit.sv ====
`timescale 1ns/100ps
`include "sys_config.svh"

module sys_unit import sys_pkg::*; (
	input logic clock,
	input logic reset,
	input logic issue,
	input logic [31:0] instr,
	input logic [`SYS_XLEN-1:0] pc,
	input logic [`SYS_XLEN-1:0] src1,
	output sys_wb_t wb,
	output logic [`SYS_XLEN-1:0] mstatus
);

	sys_cmd_t cmd;
	logic [`SYS_XLEN-1:0] rd_old;
	logic [`SYS_XLEN-1:0] mtvec;
	logic [`SYS_XLEN-1:0] mepc;

	sys_decode u_decode (
		.instr(instr),
		.src1(src1),
		.cmd(cmd)
	);

	csr_regfile u_csr (
		.clock(clock),
		.reset(reset),
		.issue(issue),
		.cmd(cmd),
		.pc(pc),
		.rd_old(rd_old),
		.mstatus(mstatus),
		.mtvec(mtvec),
		.mepc(mepc)
	);

	sys_writeback u_wb (
		.clock(clock),
		.reset(reset),
		.issue(issue),
		.cmd(cmd),
		.rd_old(rd_old),
		.mtvec(mtvec),
		.mepc(mepc),
		.wb(wb)
	);

endmodule

// ==== hw/sys_writeback.sv ====
`timescale 1ns/100ps
`include "sys_config.svh"

module sys_writeback import sys_pkg::*; (
	input logic clock,
	input logic reset,
	input logic issue,
	input sys_cmd_t cmd,
	input logic [`SYS_XLEN-1:0] rd_old,
	input logic [`SYS_XLEN-1:0] mtvec,
	input logic [`SYS_XLEN-1:0] mepc,
	output sys_wb_t wb
);

	logic rd_we_d;
	logic redirect_d;
	logic [`SYS_XLEN-1:0] target_d;

	logic valid_q;
	logic rd_we_q;
	logic redirect_q;
	logic [4:0] rd_q;
	logic [`SYS_XLEN-1:0] rd_data_q;
	logic [`SYS_XLEN-1:0] target_q;

	// x0 is never written even though the CSR side still is
	assign rd_we_d = ((cmd.op == SYS_CSRRW) || (cmd.op == SYS_CSRRS) || (cmd.op == SYS_CSRRC))
		&& (cmd.rd != 5'd0);

	assign redirect_d = (cmd.op == SYS_ECALL) || (cmd.op == SYS_MRET);

	always_comb begin
		case (cmd.op)
			SYS_ECALL: target_d = mtvec; // Trap entry
			SYS_MRET: target_d = mepc;   // Trap return
			default: target_d = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			valid_q <= 1'b0;
			rd_we_q <= 1'b0;
			redirect_q <= 1'b0;
		end else begin
			valid_q <= issue;
			rd_we_q <= issue && rd_we_d;
			redirect_q <= issue && redirect_d;
		end
	end

	// Values are taken before this edge's CSR update lands
	always_ff @(posedge clock) begin
		if (issue) begin
			rd_q <= cmd.rd;
			rd_data_q <= rd_old;
			target_q <= target_d;
		end
	end

	assign wb.valid = valid_q;
	assign wb.rd_we = rd_we_q;
	assign wb.rd = rd_q;
	assign wb.rd_data = rd_data_q;
	assign wb.redirect = redirect_q;
	assign wb.target = target_q;

endmodule

// ==== include/sys_config.svh ====
`ifndef SYS_CONFIG_SVH
`define SYS_CONFIG_SVH

// Data and pc width of the core
`define SYS_XLEN 32

// Values answered for the read-only ID registers
`define SYS_MVENDORID 32'h79737978
`define SYS_MARCHID 32'h015FDE6D

// Exception code for an environment call from machine mode
`define SYS_ECALL_CAUSE 32'd11

// MPP set to machine mode on trap entry
`define SYS_MSTATUS_TRAP 32'h00001800

`endif

// ==== sim/sys_unit_sva.sv ====
`timescale 1ns/100ps

module sys_unit_sva import sys_pkg::*; (
	input logic clock,
	input logic reset,
	input logic issue,
	input sys_wb_t wb
);

	// Every issue produces a record on the very next cycle
	valid_follows_issue: assert property (@(posedge clock) disable iff (reset)
		issue |=> wb.valid)
		else $error("wb.valid did not follow issue after one cycle");

	no_valid_without_issue: assert property (@(posedge clock) disable iff (reset)
		!issue |=> !wb.valid)
		else $error("wb.valid was high without an issue in the cycle before");

	flags_need_valid: assert property (@(posedge clock) disable iff (reset)
		(wb.rd_we || wb.redirect) |-> wb.valid)
		else $error("wb.rd_we or wb.redirect was high without wb.valid");

	// Reset flushes any record in flight
	valid_low_after_reset: assert property (@(posedge clock)
		reset |=> !wb.valid)
		else $error("wb.valid was high in the cycle after reset");

endmodule

bind sys_unit sys_unit_sva sva (
	.clock(clock),
	.reset(reset),
	.issue(issue),
	.wb(wb)
);

// ==== sim/sys_unit_tb.sv ====
`timescale 1ns/100ps
`include "sys_config.svh"

module sys_unit_tb import sys_pkg::*; ();

	typedef struct packed {
		logic [31:0] instr;
		logic [31:0] pc;
		logic [31:0] src1;
		logic back_to_back; // Next row issues in the cycle right after this one
		logic rd_we;
		logic [31:0] rd_data;
		logic redirect;
		logic [31:0] target;
		logic [31:0] mstatus;
	} row_t;

	localparam logic [2:0] F_RW = 3'b001;
	localparam logic [2:0] F_RS = 3'b010;
	localparam logic [2:0] F_RC = 3'b011;
	localparam logic [2:0] F_RWI = 3'b101;
	localparam logic [2:0] F_RSI = 3'b110;
	localparam logic [2:0] F_RCI = 3'b111;

	logic clock;
	logic reset;
	logic issue;
	logic [31:0] instr;
	logic [31:0] pc;
	logic [31:0] src1;
	sys_wb_t wb;
	logic [31:0] mstatus;

	row_t rows[$];
	logic table_ready = 1'b0;

	sys_unit dut (
		.clock(clock),
		.reset(reset),
		.issue(issue),
		.instr(instr),
		.pc(pc),
		.src1(src1),
		.wb(wb),
		.mstatus(mstatus)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	function automatic logic [31:0] csr_word(input logic [2:0] funct3, input logic [11:0] csr,
		input int rs1, input int rd);
		return {csr, rs1[4:0], funct3, rd[4:0], 7'b1110011};
	endfunction

	task automatic add_row(input logic [31:0] word, at_pc, rs1_val, b2b, we, data, redir, tgt,
		status);
		row_t r;
		r.instr = word;
		r.pc = at_pc;
		r.src1 = rs1_val;
		r.back_to_back = b2b[0];
		r.rd_we = we[0];
		r.rd_data = data;
		r.redirect = redir[0];
		r.target = tgt;
		r.mstatus = status;
		rows.push_back(r);
	endtask

	task automatic build_table();
		// Reads right after reset
		add_row(csr_word(F_RS, CSR_MSTATUS, 0, 5), 0, 0, 0, 1, 0, 0, 0, 0);
		add_row(csr_word(F_RS, CSR_MTVEC, 0, 5), 0, 0, 0, 1, 0, 0, 0, 0);
		add_row(csr_word(F_RS, CSR_MEPC, 0, 5), 0, 0, 0, 1, 0, 0, 0, 0);
		add_row(csr_word(F_RS, CSR_MCAUSE, 0, 5), 0, 0, 0, 1, 0, 0, 0, 0);
		add_row(csr_word(F_RS, CSR_MVENDORID, 0, 5), 0, 0, 0, 1, `SYS_MVENDORID, 0, 0, 0);
		add_row(csr_word(F_RS, CSR_MARCHID, 0, 5), 0, 0, 0, 1, `SYS_MARCHID, 0, 0, 0);
		add_row(csr_word(F_RS, 12'h7C0, 0, 5), 0, 0, 0, 1, 0, 0, 0, 0);
		// Read-modify-write on mtvec in register and then immediate form
		add_row(csr_word(F_RW, CSR_MTVEC, 0, 5), 0, 'h80001000, 0, 1, 0, 0, 0, 0);
		add_row(csr_word(F_RS, CSR_MTVEC, 0, 5), 0, 'hF, 0, 1, 'h80001000, 0, 0, 0);
		add_row(csr_word(F_RC, CSR_MTVEC, 0, 5), 0, 'h3, 0, 1, 'h8000100F, 0, 0, 0);
		add_row(csr_word(F_RSI, CSR_MTVEC, 16, 5), 0, 'hFFFFFFFF, 0, 1, 'h8000100C, 0, 0, 0);
		add_row(csr_word(F_RCI, CSR_MTVEC, 12, 5), 0, 'hFFFFFFFF, 0, 1, 'h8000101C, 0, 0, 0);
		add_row(csr_word(F_RWI, CSR_MSTATUS, 8, 5), 0, 'hFFFFFFFF, 0, 1, 0, 0, 0, 'h8);
		add_row(csr_word(F_RW, CSR_MARCHID, 0, 5), 0, 0, 0, 1, `SYS_MARCHID, 0, 0, 'h8);
		add_row(csr_word(F_RS, CSR_MARCHID, 0, 5), 0, 0, 0, 1, `SYS_MARCHID, 0, 0, 'h8);
		// Trap entry and the CSRs it leaves behind
		add_row(32'h00000073, 'h440, 0, 0, 0, 0, 1, 'h80001010, `SYS_MSTATUS_TRAP);
		add_row(csr_word(F_RS, CSR_MEPC, 0, 5), 0, 0, 0, 1, 'h440, 0, 0, `SYS_MSTATUS_TRAP);
		add_row(csr_word(F_RS, CSR_MCAUSE, 0, 5), 0, 0, 0, 1, `SYS_ECALL_CAUSE, 0, 0,
			`SYS_MSTATUS_TRAP);
		add_row(32'h30200073, 'h500, 0, 0, 0, 0, 1, 'h440, 0);
		// x0 destination still writes the CSR
		add_row(csr_word(F_RW, CSR_MEPC, 0, 0), 0, 'h888, 0, 0, 'h440, 0, 0, 0);
		add_row(csr_word(F_RS, CSR_MEPC, 0, 5), 0, 0, 0, 1, 'h888, 0, 0, 0);
		add_row(32'h341012B3, 0, 'h12345678, 0, 0, 'h888, 0, 0, 0); // Bits of a csrrw under the OP opcode
		add_row(csr_word(3'b100, CSR_MEPC, 3, 5), 0, 'h12345678, 0, 0, 'h888, 0, 0, 0);
		add_row(csr_word(F_RS, CSR_MEPC, 0, 5), 0, 0, 0, 1, 'h888, 0, 0, 0);
		// Back-to-back pairs where each read sees the write before it
		add_row(csr_word(F_RW, CSR_MCAUSE, 0, 5), 0, 'h7, 1, 1, `SYS_ECALL_CAUSE, 0, 0, 0);
		add_row(csr_word(F_RS, CSR_MCAUSE, 0, 6), 0, 0, 0, 1, 'h7, 0, 0, 0);
		add_row(csr_word(F_RWI, CSR_MSTATUS, 31, 5), 0, 0, 1, 1, 0, 0, 0, 'h1F);
		add_row(csr_word(F_RC, CSR_MSTATUS, 0, 5), 0, 'h1, 0, 1, 'h1F, 0, 0, 'h1E);
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		assert (actual === expected) else begin
			$display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
			$display("Test failed");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic check_record(input row_t r);
		check_value("wb.valid", 32'(wb.valid), 1);
		check_value("wb.rd", 32'(wb.rd), 32'(r.instr[11:7]));
		check_value("wb.rd_we", 32'(wb.rd_we), 32'(r.rd_we));
		check_value("wb.rd_data", wb.rd_data, r.rd_data);
		check_value("wb.redirect", 32'(wb.redirect), 32'(r.redirect));
		check_value("wb.target", wb.target, r.target);
		check_value("mstatus", mstatus, r.mstatus);
	endtask

	initial begin
		row_t r;
		reset = 1'b1;
		issue = 1'b0;
		instr = '0;
		pc = '0;
		src1 = '0;
		build_table();
		table_ready = 1'b1;
		repeat (3) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		check_value("wb.valid", 32'(wb.valid), 0);
		check_value("mstatus", mstatus, 0);
		foreach (rows[i]) begin
			r = rows[i];
			instr = r.instr;
			pc = r.pc;
			src1 = r.src1;
			issue = 1'b1;
			@(negedge clock);
			check_record(r);
			if (!r.back_to_back) begin
				issue = 1'b0;
				@(negedge clock);
				check_value("wb.valid", 32'(wb.valid), 0); // Idle cycle carries no record
			end
		end
		$display("Test passed");
		$finish;
	end

	// Each row needs at most two cycles, so three per row plus a margin is ample
	initial begin
		wait (table_ready);
		repeat (rows.size() * 3 + 20) @(posedge clock);
		$display("Timeout: the table was not finished within %0d cycles", rows.size() * 3 + 20);
		$display("Test failed");
		$fatal(1, "Watchdog expired");
	end

endmodule
